// ==== decode_subsys.f ====
+incdir+hw
hw/decode_pkg.sv
hw/reg_read_if.sv
hw/register_bank.sv
hw/control.sv
hw/hazard_control.sv
hw/decode_stage.sv
hw/decode_subsys.sv
testbench/decode_subsys_assert.sv
testbench/decode_subsys_tb.sv

// ==== testbench/decode_subsys_tb.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_subsys_tb
   import decode_pkg::*;
();

   logic                   clk;
   logic                   rst_n;
   logic                   enable;
   logic [`ADDR_SIZE-1:0]  pc;
   logic [`INSTR_SIZE-1:0] instruction;
   logic                   ex_regwrite, m_regwrite, wb_we;
   logic [`REG_ADDR-1:0]   ex_dest_reg, m_dest_reg, wb_addr;
   logic [`REG_SIZE-1:0]   wb_data;
   logic                   pc_write, if_id_write, is_mult;
   logic                   regwrite, memtoreg, branch, memwrite, memread, byteword, alusrc;
   logic [`ADDR_SIZE-1:0]  out_pc, mimmediat;
   logic [`REG_SIZE-1:0]   rout_reg1, rout_reg2;
   logic [`REG_ADDR-1:0]   dest_reg;
   opcode_e                op_code;
   funct_e                 funct_code;
   logic [6:0]             ctrl_bits;

   // One stimulus row and what the boundary should show a cycle later
   typedef struct {
      string                  name;
      logic                   en;
      logic [`ADDR_SIZE-1:0]  pc;
      logic [`INSTR_SIZE-1:0] instr;
      logic                   ex_rw;
      logic [`REG_ADDR-1:0]   ex_dst;
      logic                   m_rw;
      logic [`REG_ADDR-1:0]   m_dst;
      logic                   pcw;     // Same-cycle pc_write
      logic [6:0]             ctrl;    // After any bubble
      logic                   mult;
      logic [`ADDR_SIZE-1:0]  imm;
      logic [`REG_ADDR-1:0]   dst;
   } row_t;

   row_t                 rows[$];
   logic [`REG_SIZE-1:0] model [`NUM_REGS];  // Mirror of the bank
   int                   errors;
   int                   seed;
   int                   ref_idx;             // Last row that loaded the boundary
   int                   wait_cnt;

   decode_subsys u_decode_subsys (.*);

   assign ctrl_bits = {regwrite, memtoreg, branch, memwrite, memread, byteword, alusrc};

   always #2 clk = ~clk;  // 4 ns period

   task automatic add_row(input string n, input logic en, input logic [31:0] p, i,
                          input logic exr, input logic [4:0] exd, input logic mr,
                          input logic [4:0] md, input logic pcw, input logic [6:0] ctrl,
                          input logic mult, input logic [31:0] imm, input logic [4:0] d);
      rows.push_back(row_t'{n, en, p, i, exr, exd, mr, md, pcw, ctrl, mult, imm, d});
   endtask

   task automatic check_value(input string name, input string field,
                              input logic [31:0] exp_val, input logic [31:0] act_val);
      assert (act_val === exp_val) else begin
         $display("Mismatch %s %s: expected %h, actual %h", name, field, exp_val, act_val);
         errors++;
      end
   endtask

   task automatic drive_row(input row_t r);
      enable      <= r.en;
      pc          <= r.pc;
      instruction <= r.instr;
      ex_regwrite <= r.ex_rw;
      ex_dest_reg <= r.ex_dst;
      m_regwrite  <= r.m_rw;
      m_dest_reg  <= r.m_dst;
      wb_we       <= 1'b0;  // Preload over
   endtask

   // Register data comes from the mirror, src fields at 25..21 and 20..16
   task automatic check_boundary(input string name, input row_t r);
      check_value(name, "out_pc", r.pc, out_pc);
      check_value(name, "rout_reg1", model[r.instr[25:21]], rout_reg1);
      check_value(name, "rout_reg2", model[r.instr[20:16]], rout_reg2);
      check_value(name, "dest_reg", r.dst, dest_reg);
      check_value(name, "mimmediat", r.imm, mimmediat);
      check_value(name, "op_code", r.instr[31:26], op_code);     // Opcode field
      check_value(name, "funct_code", r.instr[5:0], funct_code); // Funct field
      check_value(name, "ctrl", r.ctrl, ctrl_bits);
      check_value(name, "is_mult", r.mult, is_mult);
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      enable      = 1'b0;
      pc          = '0;
      instruction = '0;
      ex_regwrite = 1'b0;
      ex_dest_reg = '0;
      m_regwrite  = 1'b0;
      m_dest_reg  = '0;
      wb_we       = 1'b0;
      wb_addr     = '0;
      wb_data     = '0;
      errors      = 0;
      seed        = 11643;
      ref_idx     = 0;

      // ctrl order {regwrite, memtoreg, branch, memwrite, memread, byteword, alusrc}
      add_row("rtype_add", 1, 'h100, 'h03fe1820, 0, 0, 0, 0, 1, 'b1000000, 0, 'h1820, 3);
      add_row("rtype_mul", 1, 'h104, 'h00052018, 0, 0, 0, 0, 1, 'b1000000, 1, 'h2018, 4);
      add_row("addi_neg", 1, 'h108, 'h2046fff0, 0, 0, 0, 0, 1, 'b1000001, 0, 'hfffffff0, 31);
      add_row("lw", 1, 'h10c, 'h8ce80044, 0, 0, 0, 0, 1, 'b1100111, 0, 'h44, 0);
      add_row("lb_neg", 1, 'h110, 'h81204001, 0, 0, 0, 0, 1, 'b1100101, 0, 'hffffc001, 8);
      add_row("sw", 1, 'h114, 'had4b0008, 0, 0, 0, 0, 1, 'b0001011, 0, 'h8, 0);
      add_row("sb", 1, 'h118, 'ha18d0010, 0, 0, 0, 0, 1, 'b0001001, 0, 'h10, 0);
      add_row("beq_pos", 1, 'h11c, 'h10a600f0, 0, 0, 0, 0, 1, 'b0010000, 0, 'h28f0, 0);
      add_row("beq_neg", 1, 'h120, 'h11110203, 0, 0, 0, 0, 1, 'b0010000, 0, 'hffffc603, 0);
      add_row("jump_neg", 1, 'h124, 'h09821234, 0, 0, 0, 0, 1, 'b0010000, 0, 'hfffc1234, 2);
      add_row("jump_pos", 1, 'h128, 'h08747fff, 0, 0, 0, 0, 1, 'b0010000, 0, 'h3ffff, 15);
      add_row("undef_op", 1, 'h12c, 'hfdcf0800, 0, 0, 0, 0, 1, 'b0000000, 0, 'h800, 1);
      add_row("hold", 0, 'h999, 'h20210001, 0, 0, 0, 0, 1, 'b0000000, 0, 'h0, 0);
      add_row("ex_haz", 1, 'h130, 'h22110005, 1, 16, 0, 0, 0, 'b0000000, 0, 'h5, 0);
      add_row("mem_haz", 1, 'h134, 'h02533018, 0, 0, 1, 19, 0, 'b0000000, 0, 'h3018, 6);
      add_row("r0_no_stall", 1, 'h138, 'h00150820, 1, 0, 1, 0, 1, 'b1000000, 0, 'h820, 1);
      add_row("wr_off", 1, 'h13c, 'h8ed70004, 0, 22, 0, 23, 1, 'b1100111, 0, 'h4, 0);

      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      wait_cnt = 0;
      while (rst_n !== 1'b1 && wait_cnt < 20) begin
         @(posedge clk);
         wait_cnt++;
      end
      if (rst_n !== 1'b1) begin
         $display("Reset was never released");
         errors++;
      end
      @(negedge clk);
      check_value("reset", "ctrl", 0, ctrl_bits);  // Cleared boundary
      check_value("reset", "is_mult", 0, is_mult);

      // Preload r1..r31, r31 lands one edge before the first row reads it
      model[0] = '0;
      for (int r = 1; r < `NUM_REGS; r++) begin
         @(posedge clk);
         model[r] = $random(seed);
         wb_we   <= 1'b1;
         wb_addr <= r[`REG_ADDR-1:0];
         wb_data <= model[r];
      end

      // Row i driven here, row i-1 seen on the boundary
      for (int i = 0; i <= rows.size(); i++) begin
         @(posedge clk);
         if (i < rows.size()) begin
            drive_row(rows[i]);
         end else begin
            enable <= 1'b0;  // Drain
         end
         @(negedge clk);
         if (i < rows.size()) begin
            check_value(rows[i].name, "pc_write", rows[i].pcw, pc_write);
            check_value(rows[i].name, "if_id_write", rows[i].pcw, if_id_write);
         end
         if (i > 0) begin
            if (rows[i-1].en) begin
               ref_idx = i - 1;
            end
            check_boundary(rows[i-1].name, rows[ref_idx]);  // Held rows reuse last load
         end
      end

      $display("Checks finished with %0d errors", errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== testbench/decode_subsys_assert.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_subsys_assert (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   enable,
   input logic                   stall,        // Hazard detector output inside decode
   input logic [`INSTR_SIZE-1:0] instruction,
   input logic                   ex_regwrite,
   input logic [`REG_ADDR-1:0]   ex_dest_reg,
   input logic                   m_regwrite,
   input logic [`REG_ADDR-1:0]   m_dest_reg,
   input logic                   pc_write,
   input logic                   if_id_write,
   input logic                   regwrite,
   input logic                   memwrite,
   input logic                   memread,
   input logic                   branch
);

   logic [`REG_ADDR-1:0] src1;
   logic [`REG_ADDR-1:0] src2;
   logic                 hazard;

   assign src1 = instruction[25:21];
   assign src2 = instruction[20:16];

   // RAW against EX or MEM, r0 excluded
   assign hazard = (ex_regwrite && (ex_dest_reg != '0) &&
                    ((ex_dest_reg == src1) || (ex_dest_reg == src2))) ||
                   (m_regwrite && (m_dest_reg != '0) &&
                    ((m_dest_reg == src1) || (m_dest_reg == src2)));

   // Fetch and IF/ID freeze together, exactly on a hazard
   a_write_pair: assert property (@(posedge clk) disable iff (!rst_n)
      (pc_write == if_id_write) && (pc_write == !hazard))
      else $error("Fetch write enables disagree with the hazard inputs");

   // Stalled slot must leave no side effects downstream
   a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
      (stall && enable) |=> !(regwrite || memwrite || memread || branch))
      else $error("Control bits not cleared after a stall");

   a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !(memread && memwrite))  // Load and store at once
      else $error("memread and memwrite both high");

endmodule

bind decode_stage decode_subsys_assert u_decode_subsys_assert (
   .clk         (clk),
   .rst_n       (rst_n),
   .enable      (enable),
   .stall       (stall),
   .instruction (instruction),
   .ex_regwrite (ex_regwrite),
   .ex_dest_reg (ex_dest_reg),
   .m_regwrite  (m_regwrite),
   .m_dest_reg  (m_dest_reg),
   .pc_write    (pc_write),
   .if_id_write (if_id_write),
   .regwrite    (regwrite),
   .memwrite    (memwrite),
   .memread     (memread),
   .branch      (branch)
);

// ==== hw/decode_subsys.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_subsys
   import decode_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   enable,
   input  logic [`ADDR_SIZE-1:0]  pc,
   input  logic [`INSTR_SIZE-1:0] instruction,
   input  logic                   ex_regwrite,
   input  logic [`REG_ADDR-1:0]   ex_dest_reg,
   input  logic                   m_regwrite,
   input  logic [`REG_ADDR-1:0]   m_dest_reg,
   output logic                   pc_write,
   output logic                   if_id_write,
   output logic [`ADDR_SIZE-1:0]  out_pc,
   output logic [`REG_SIZE-1:0]   rout_reg1,
   output logic [`REG_SIZE-1:0]   rout_reg2,
   output logic [`REG_ADDR-1:0]   dest_reg,
   output logic [`ADDR_SIZE-1:0]  mimmediat,
   output opcode_e                op_code,
   output funct_e                 funct_code,
   output logic                   is_mult,
   output logic                   regwrite,
   output logic                   memtoreg,
   output logic                   branch,
   output logic                   memwrite,
   output logic                   memread,
   output logic                   byteword,
   output logic                   alusrc,
   input  logic                   wb_we,    // Writeback port into the bank
   input  logic [`REG_ADDR-1:0]   wb_addr,
   input  logic [`REG_SIZE-1:0]   wb_data
);

   reg_read_if rd_bus ();  // Decode to bank read path

   decode_stage u_decode_stage (
      .clk         (clk),
      .rst_n       (rst_n),
      .enable      (enable),
      .pc          (pc),
      .instruction (instruction),
      .rd          (rd_bus.stage),
      .ex_regwrite (ex_regwrite),
      .ex_dest_reg (ex_dest_reg),
      .m_regwrite  (m_regwrite),
      .m_dest_reg  (m_dest_reg),
      .pc_write    (pc_write),
      .if_id_write (if_id_write),
      .out_pc      (out_pc),
      .rout_reg1   (rout_reg1),
      .rout_reg2   (rout_reg2),
      .dest_reg    (dest_reg),
      .mimmediat   (mimmediat),
      .op_code     (op_code),
      .funct_code  (funct_code),
      .is_mult     (is_mult),
      .regwrite    (regwrite),
      .memtoreg    (memtoreg),
      .branch      (branch),
      .memwrite    (memwrite),
      .memread     (memread),
      .byteword    (byteword),
      .alusrc      (alusrc)
   );

   register_bank u_register_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd      (rd_bus.bank),
      .wb_we   (wb_we),
      .wb_addr (wb_addr),
      .wb_data (wb_data)
   );

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module decode_stage
   import decode_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   enable,       // Boundary load enable
   input  logic [`ADDR_SIZE-1:0]  pc,
   input  logic [`INSTR_SIZE-1:0] instruction,
   reg_read_if.stage              rd,           // Register bank read ports
   input  logic                   ex_regwrite,
   input  logic [`REG_ADDR-1:0]   ex_dest_reg,
   input  logic                   m_regwrite,
   input  logic [`REG_ADDR-1:0]   m_dest_reg,
   output logic                   pc_write,     // Low while stalled
   output logic                   if_id_write,  // Low while stalled
   output logic [`ADDR_SIZE-1:0]  out_pc,
   output logic [`REG_SIZE-1:0]   rout_reg1,
   output logic [`REG_SIZE-1:0]   rout_reg2,
   output logic [`REG_ADDR-1:0]   dest_reg,
   output logic [`ADDR_SIZE-1:0]  mimmediat,
   output opcode_e                op_code,
   output funct_e                 funct_code,
   output logic                   is_mult,      // EX: use the multiply pipe
   output logic                   regwrite,
   output logic                   memtoreg,
   output logic                   branch,
   output logic                   memwrite,
   output logic                   memread,
   output logic                   byteword,
   output logic                   alusrc
);

   opcode_e               opcode;
   funct_e                funct;
   logic [`REG_ADDR-1:0]  dst;
   logic [`ADDR_SIZE-1:0] imm_ext;
   logic                  stall;

   // Fixed ISA field positions
   assign opcode      = opcode_e'(instruction[31:26]);
   assign rd.src_reg1 = instruction[25:21];
   assign rd.src_reg2 = instruction[20:16];
   assign dst         = instruction[15:11];
   assign funct       = funct_e'(instruction[5:0]);

   // Immediate formats
   always_comb begin
      case (opcode)
         OP_BEQ: begin
            // Split offset, sign from bit 24
            imm_ext = {{(`ADDR_SIZE-15){instruction[24]}}, instruction[24:20],
                       instruction[9:0]};
         end
         OP_JUMP: begin
            imm_ext = {{(`ADDR_SIZE-20){instruction[24]}}, instruction[24:20],
                       instruction[14:0]};
         end
         default: begin
            imm_ext = {{(`ADDR_SIZE-15){instruction[14]}}, instruction[14:0]};
         end
      endcase
   end

   // Data fields load even during a stall
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_pc     <= '0;
         rout_reg1  <= '0;
         rout_reg2  <= '0;
         dest_reg   <= '0;
         mimmediat  <= '0;
         op_code    <= opcode_e'(0);
         funct_code <= funct_e'(0);
         is_mult    <= 1'b0;
      end else if (enable) begin
         out_pc     <= pc;
         rout_reg1  <= rd.rdata1;
         rout_reg2  <= rd.rdata2;
         dest_reg   <= dst;
         mimmediat  <= imm_ext;
         op_code    <= opcode;
         funct_code <= funct;
         is_mult    <= !stall && (opcode == OP_RTYPE) && (funct == FN_MUL);  // Bubbled too
      end
   end

   // Control bits, registered inside
   control u_control (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (enable),
      .stall    (stall),
      .opcode   (opcode),
      .regwrite (regwrite),
      .memtoreg (memtoreg),
      .branch   (branch),
      .memwrite (memwrite),
      .memread  (memread),
      .byteword (byteword),
      .alusrc   (alusrc)
   );

   hazard_control u_hazard_control (
      .d_src1      (rd.src_reg1),
      .d_src2      (rd.src_reg2),
      .ex_regwrite (ex_regwrite),
      .ex_dest_reg (ex_dest_reg),
      .m_regwrite  (m_regwrite),
      .m_dest_reg  (m_dest_reg),
      .stall       (stall)
   );

   // Freeze fetch and IF/ID while the hazard lasts
   assign pc_write    = ~stall;
   assign if_id_write = ~stall;

endmodule

// ==== hw/hazard_control.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module hazard_control (
   input  logic [`REG_ADDR-1:0] d_src1,
   input  logic [`REG_ADDR-1:0] d_src2,
   input  logic                 ex_regwrite,  // EX instruction writes back
   input  logic [`REG_ADDR-1:0] ex_dest_reg,
   input  logic                 m_regwrite,   // MEM instruction writes back
   input  logic [`REG_ADDR-1:0] m_dest_reg,
   output logic                 stall
);

   logic ex_hit;
   logic m_hit;

   // r0 never holds a result, so no stall on it
   assign ex_hit = ex_regwrite && (ex_dest_reg != '0) &&
                   ((ex_dest_reg == d_src1) || (ex_dest_reg == d_src2));
   assign m_hit  = m_regwrite && (m_dest_reg != '0) &&
                   ((m_dest_reg == d_src1) || (m_dest_reg == d_src2));

   assign stall = ex_hit || m_hit;  // Either stage ahead still pending

endmodule

// ==== hw/control.sv ====
`timescale 1ns/1ps

module control
   import decode_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    enable,    // Boundary load enable
   input  logic    stall,     // Hazard, load a bubble
   input  opcode_e opcode,
   output logic    regwrite,  // WB: write the register file
   output logic    memtoreg,  // WB: result from memory, not ALU
   output logic    branch,    // MEM: redirect fetch
   output logic    memwrite,  // MEM: store
   output logic    memread,   // MEM: load
   output logic    byteword,  // MEM: word (1) or byte (0) access
   output logic    alusrc     // EX: second operand is the immediate
);

   // Bit order {regwrite, memtoreg, branch, memwrite, memread, byteword, alusrc}
   logic [6:0] ctrl_d;
   logic [6:0] ctrl_q;

   always_comb begin
      case (opcode)
         OP_RTYPE: ctrl_d = 7'b1000000;
         OP_ADDI:  ctrl_d = 7'b1000001;
         OP_LW:    ctrl_d = 7'b1100111;
         OP_LB:    ctrl_d = 7'b1100101;  // Same as LW, byte access
         OP_SW:    ctrl_d = 7'b0001011;
         OP_SB:    ctrl_d = 7'b0001001;
         OP_BEQ:   ctrl_d = 7'b0010000;
         OP_JUMP:  ctrl_d = 7'b0010000;  // Jump rides the branch path
         default:  ctrl_d = 7'b0000000;  // Unknown opcode acts as a nop
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_q <= '0;
      end else if (enable) begin
         ctrl_q <= stall ? '0 : ctrl_d;  // Bubble on hazard
      end
   end

   assign regwrite = ctrl_q[6];
   assign memtoreg = ctrl_q[5];
   assign branch   = ctrl_q[4];
   assign memwrite = ctrl_q[3];
   assign memread  = ctrl_q[2];
   assign byteword = ctrl_q[1];
   assign alusrc   = ctrl_q[0];

endmodule

// ==== hw/register_bank.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

module register_bank (
   input  logic                 clk,
   input  logic                 rst_n,
   reg_read_if.bank             rd,       // Two combinational read ports
   input  logic                 wb_we,    // Writeback enable
   input  logic [`REG_ADDR-1:0] wb_addr,  // Writeback destination
   input  logic [`REG_SIZE-1:0] wb_data   // Writeback value
);

   logic [`REG_SIZE-1:0] regs [`NUM_REGS];

   // Reads see only earlier writes
   // Register 0 is hardwired to zero
   assign rd.rdata1 = (rd.src_reg1 == '0) ? '0 : regs[rd.src_reg1];
   assign rd.rdata2 = (rd.src_reg2 == '0) ? '0 : regs[rd.src_reg2];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;  // Whole bank clears
         end
      end else if (wb_we && (wb_addr != '0)) begin
         regs[wb_addr] <= wb_data;  // Writes to r0 dropped
      end
   end

endmodule

// ==== hw/reg_read_if.sv ====
`timescale 1ns/1ps
`include "decode_config.svh"

// Two read ports between decode and the register bank
interface reg_read_if;

   logic [`REG_ADDR-1:0] src_reg1;  // Read address, port 1
   logic [`REG_ADDR-1:0] src_reg2;  // Read address, port 2
   logic [`REG_SIZE-1:0] rdata1;    // Read data, port 1
   logic [`REG_SIZE-1:0] rdata2;    // Read data, port 2

   // Decode side issues addresses
   modport stage (
      output src_reg1,
      output src_reg2,
      input  rdata1,
      input  rdata2
   );

   // Bank side answers combinationally
   modport bank (
      input  src_reg1,
      input  src_reg2,
      output rdata1,
      output rdata2
   );

endinterface

// ==== hw/decode_pkg.sv ====
`include "decode_config.svh"

package decode_pkg;

   // Primary opcodes, bits 31..26 of the instruction
   // Values outside this list are legal and decode to no control bits
   typedef enum logic [`OPCODE_SIZE-1:0] {
      OP_RTYPE = 6'h00,  // Register-register ALU ops
      OP_JUMP  = 6'h02,  // Unconditional jump
      OP_BEQ   = 6'h04,  // Branch if equal
      OP_ADDI  = 6'h08,  // Add immediate
      OP_LB    = 6'h20,  // Load byte
      OP_LW    = 6'h23,  // Load word
      OP_SB    = 6'h28,  // Store byte
      OP_SW    = 6'h2B   // Store word
   } opcode_e;

   // Function codes for RTYPE, bits 5..0
   typedef enum logic [`FUNCT_SIZE-1:0] {
      FN_MUL = 6'h18,  // Routed to the multiply pipe
      FN_ADD = 6'h20,
      FN_SUB = 6'h22
   } funct_e;

endpackage

// ==== hw/decode_config.svh ====
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// PC and immediate width
`define ADDR_SIZE 32

// Instruction word width
`define INSTR_SIZE 32

// Register address and data widths
`define REG_ADDR 5
`define REG_SIZE 32

// Register bank depth
`define NUM_REGS 32

// Opcode and funct field widths, fixed by the ISA
`define OPCODE_SIZE 6
`define FUNCT_SIZE 6

`endif
